// File: source/pipe_pkg.sv
// ====================================================================
// pipeline definitions shared by the memory stage
// bundle structs between stages, access size encoding and the
// register index constants used by forwarding
// ====================================================================

package pipe_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;
    localparam int ram_words = 1024;
    localparam int ram_idx_w = $clog2(ram_words);

    // x0 never forwards
    localparam logic [reg_idx_w-1:0] reg_x0 = '0;

    // same coding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_e;

    // execute to memory
    typedef struct packed {
        logic                 valid;
        logic [xlen-1:0]      pc;
        logic [reg_idx_w-1:0] rd;
        logic                 write_gpr;
        logic                 mem_read;
        logic                 mem_write;
        mem_size_e            size;
        logic                 is_unsigned;
        logic [xlen-1:0]      alu_out;
        logic [xlen-1:0]      store_data;
    } ex_mem_t;

    // memory to writeback
    typedef struct packed {
        logic                 valid;
        logic [xlen-1:0]      pc;
        logic [reg_idx_w-1:0] rd;
        logic                 write_gpr;
        logic [xlen-1:0]      result;
    } mem_wb_t;

    typedef struct packed {
        logic                 write_gpr;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      data;
    } wb_fwd_t;

    typedef struct packed {
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
    } ex_srcs_t;

    typedef struct packed {
        logic            rs1_hit;
        logic [xlen-1:0] rs1_data;
        logic            rs2_hit;
        logic [xlen-1:0] rs2_data;
    } fwd_t;

    typedef struct packed {
        logic stall_if;
        logic stall_id;
        logic stall_ex;
        logic stall_mem;
    } stall_t;

endpackage

// File: source/axi_lite_pkg.sv
// ====================================================================
// AXI4-Lite channel payloads for the data port
// valid and ready travel as separate wires next to each struct
// ====================================================================

package axi_lite_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    localparam logic [1:0] resp_okay = 2'b00;

    // unprivileged, secure, data access
    localparam logic [2:0] prot_data = 3'b000;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        prot;
    } axi_aw_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        prot;
    } axi_ar_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [1:0]        resp;
    } axi_r_t;

endpackage

// File: source/load_store_unit.sv
// ====================================================================
// load/store unit
// runs one AXI4-Lite access per memory bundle, places store data on
// the byte lanes, extends load data and registers the writeback bundle
// ====================================================================

`timescale 1ns/10ps

module load_store_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pipe_pkg::ex_mem_t     mem_in,
    output axi_lite_pkg::axi_aw_t aw,
    output logic                  awvalid,
    input  logic                  awready,
    output axi_lite_pkg::axi_w_t  w,
    output logic                  wvalid,
    input  logic                  wready,
    input  axi_lite_pkg::axi_b_t  b,
    input  logic                  bvalid,
    output logic                  bready,
    output axi_lite_pkg::axi_ar_t ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  axi_lite_pkg::axi_r_t  r,
    input  logic                  rvalid,
    output logic                  rready,
    output logic                  busy,
    output logic                  done,
    output logic [31:0]           load_data,
    output pipe_pkg::mem_wb_t     wb_out
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_resp,
        st_complete
    } state_e;

    state_e            state_q;
    state_e            state_d;
    pipe_pkg::ex_mem_t last_q;
    logic              same_bundle;
    logic              can_take;
    logic              start;
    logic              start_mem;
    logic              is_load;
    logic              addr_done;
    logic              resp_fire;
    logic              wb_fire;
    logic [1:0]        offset;
    logic [3:0]        strb;
    logic [31:0]       lane;

    assign offset  = mem_in.alu_out[1:0];
    assign is_load = mem_in.mem_read && !mem_in.mem_write;

    // a held bundle that already finished must not run again
    assign same_bundle = (mem_in == last_q);
    assign can_take    = (state_q == st_idle) || (state_q == st_complete && !same_bundle);
    assign start       = can_take && mem_in.valid;
    assign start_mem   = start && (mem_in.mem_read || mem_in.mem_write);

    assign addr_done = (!awvalid || awready) && (!wvalid || wready) && (!arvalid || arready);
    assign bready    = (state_q == st_resp);
    assign rready    = (state_q == st_resp);
    assign resp_fire = (bvalid && bready) || (rvalid && rready);

    assign busy    = start_mem || (state_q == st_addr) || (state_q == st_resp && !resp_fire);
    assign done    = resp_fire;
    assign wb_fire = (start && !start_mem) || resp_fire;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle, st_complete: begin
                if (start_mem) begin
                    state_d = st_addr;
                end else if (start) begin
                    state_d = st_complete;
                end else if (!same_bundle) begin
                    state_d = st_idle;
                end
            end
            st_addr: begin
                if (addr_done) begin
                    state_d = st_resp;
                end
            end
            st_resp: begin
                if (resp_fire) begin
                    state_d = st_complete;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    // ================================================================
    // lane handling
    // ================================================================

    always_comb begin
        case (mem_in.size)
            pipe_pkg::size_byte: strb = 4'b0001 << offset;
            pipe_pkg::size_half: strb = 4'b0011 << offset;
            default:             strb = 4'b1111;
        endcase
    end

    assign lane = r.data >> {offset, 3'b000};

    always_comb begin
        case (mem_in.size)
            pipe_pkg::size_byte: begin
                load_data = mem_in.is_unsigned ? {24'b0, lane[7:0]}
                                               : {{24{lane[7]}}, lane[7:0]};
            end
            pipe_pkg::size_half: begin
                load_data = mem_in.is_unsigned ? {16'b0, lane[15:0]}
                                               : {{16{lane[15]}}, lane[15:0]};
            end
            default: load_data = r.data;
        endcase
    end

    // ================================================================
    // registers
    // ================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start_mem) begin
                awvalid <= mem_in.mem_write;
                wvalid  <= mem_in.mem_write;
                arvalid <= is_load;
            end else begin
                awvalid <= awvalid && !awready;
                wvalid  <= wvalid && !wready;
                arvalid <= arvalid && !arready;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            last_q <= mem_in;
        end
        if (start_mem) begin
            aw.addr <= mem_in.alu_out;
            aw.prot <= axi_lite_pkg::prot_data;
            ar.addr <= mem_in.alu_out;
            ar.prot <= axi_lite_pkg::prot_data;
            w.data  <= mem_in.store_data << {offset, 3'b000};
            w.strb  <= strb;
        end
    end

    // stores never write a register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_out.valid <= 1'b0;
        end else begin
            wb_out.valid <= wb_fire;
            if (wb_fire) begin
                wb_out.pc        <= mem_in.pc;
                wb_out.rd        <= mem_in.rd;
                wb_out.write_gpr <= mem_in.write_gpr && !mem_in.mem_write;
                wb_out.result    <= is_load ? load_data : mem_in.alu_out;
            end
        end
    end

endmodule

// File: source/data_ram_axi.sv
// ====================================================================
// data RAM behind an AXI4-Lite slave port
// word array with byte strobes, one response a cycle after each
// accepted address, always OKAY
// ====================================================================

`timescale 1ns/10ps

module data_ram_axi (
    input  logic                  clk,
    input  logic                  rst_n,
    input  axi_lite_pkg::axi_aw_t aw,
    input  logic                  awvalid,
    output logic                  awready,
    input  axi_lite_pkg::axi_w_t  w,
    input  logic                  wvalid,
    output logic                  wready,
    output axi_lite_pkg::axi_b_t  b,
    output logic                  bvalid,
    input  logic                  bready,
    input  axi_lite_pkg::axi_ar_t ar,
    input  logic                  arvalid,
    output logic                  arready,
    output axi_lite_pkg::axi_r_t  r,
    output logic                  rvalid,
    input  logic                  rready
);

    logic [31:0] mem [pipe_pkg::ram_words] = '{default: '0};

    logic [pipe_pkg::ram_idx_w-1:0] widx;
    logic [pipe_pkg::ram_idx_w-1:0] ridx;
    logic                           wr_fire;
    logic                           rd_fire;
    logic [31:0]                    rdata_q;

    // word index wraps at the array depth
    assign widx = aw.addr[2 +: pipe_pkg::ram_idx_w];
    assign ridx = ar.addr[2 +: pipe_pkg::ram_idx_w];

    // address and data are taken together, never while B is pending
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;

    assign b = '{resp: axi_lite_pkg::resp_okay};
    assign r = '{data: rdata_q, resp: axi_lite_pkg::resp_okay};

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) begin
                    mem[widx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
        if (rd_fire) begin
            rdata_q <= mem[ridx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            bvalid <= wr_fire || (bvalid && !bready);
            rvalid <= rd_fire || (rvalid && !rready);
        end
    end

endmodule

// File: source/hazard_forward.sv
// ====================================================================
// hazard and forwarding unit
// bypass operands for the execute stage and the stall flags for the
// earlier stages, all combinational
// ====================================================================

`timescale 1ns/10ps

module hazard_forward (
    input  pipe_pkg::ex_mem_t  mem_in,
    input  logic               busy,
    input  logic               done,
    input  logic [31:0]        load_data,
    input  pipe_pkg::ex_srcs_t ex_srcs,
    input  pipe_pkg::wb_fwd_t  wb_fwd,
    output pipe_pkg::fwd_t     fwd,
    output pipe_pkg::stall_t   stall
);

    logic mem_wr;
    logic mem_load;
    logic rd_is_src;
    logic load_use;

    // stores do not write back even with write_gpr set
    assign mem_wr   = mem_in.valid && mem_in.write_gpr && !mem_in.mem_write;
    assign mem_load = mem_in.mem_read && !mem_in.mem_write;

    // ================================================================
    // bypass selection
    // ================================================================

    // returns {hit, data}
    function automatic logic [pipe_pkg::xlen:0] bypass(
        input logic [pipe_pkg::reg_idx_w-1:0] rs
    );
        logic mem_match;
        logic wb_match;
        mem_match = (rs != pipe_pkg::reg_x0) && mem_wr && (mem_in.rd == rs);
        wb_match  = (rs != pipe_pkg::reg_x0) && wb_fwd.write_gpr && (wb_fwd.rd == rs);
        if (mem_match) begin
            if (!mem_load) begin
                return {1'b1, mem_in.alu_out};
            end
            if (done) begin
                return {1'b1, load_data};
            end
            // load still in flight, older writeback value would be stale
            return '0;
        end
        if (wb_match) begin
            return {1'b1, wb_fwd.data};
        end
        return '0;
    endfunction

    always_comb begin
        {fwd.rs1_hit, fwd.rs1_data} = bypass(ex_srcs.rs1);
        {fwd.rs2_hit, fwd.rs2_data} = bypass(ex_srcs.rs2);
    end

    // ================================================================
    // stalls
    // ================================================================

    assign rd_is_src = (mem_in.rd != pipe_pkg::reg_x0)
                    && ((mem_in.rd == ex_srcs.rs1) || (mem_in.rd == ex_srcs.rs2));

    assign load_use = mem_wr && mem_load && rd_is_src && !done;

    always_comb begin
        stall.stall_mem = busy;
        stall.stall_ex  = busy || load_use;
        stall.stall_id  = busy || load_use;
        stall.stall_if  = busy || load_use;
    end

endmodule

// File: source/mem_stage.sv
// ====================================================================
// memory access stage of the RV32I pipeline
// load/store unit with its data RAM plus the hazard unit
// ====================================================================

`timescale 1ns/10ps

module mem_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  pipe_pkg::ex_mem_t  mem_in,
    input  pipe_pkg::ex_srcs_t ex_srcs,
    input  pipe_pkg::wb_fwd_t  wb_fwd,
    output pipe_pkg::mem_wb_t  wb_out,
    output pipe_pkg::fwd_t     fwd,
    output pipe_pkg::stall_t   stall
);

    // data port
    axi_lite_pkg::axi_aw_t aw;
    logic                  awvalid;
    logic                  awready;
    axi_lite_pkg::axi_w_t  w;
    logic                  wvalid;
    logic                  wready;
    axi_lite_pkg::axi_b_t  b;
    logic                  bvalid;
    logic                  bready;
    axi_lite_pkg::axi_ar_t ar;
    logic                  arvalid;
    logic                  arready;
    axi_lite_pkg::axi_r_t  r;
    logic                  rvalid;
    logic                  rready;

    // unit status toward the hazard logic
    logic                  busy;
    logic                  done;
    logic [31:0]           load_data;

    load_store_unit i_lsu (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_in    (mem_in),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .b         (b),
        .bvalid    (bvalid),
        .bready    (bready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .busy      (busy),
        .done      (done),
        .load_data (load_data),
        .wb_out    (wb_out)
    );

    data_ram_axi i_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    hazard_forward i_hazard (
        .mem_in    (mem_in),
        .busy      (busy),
        .done      (done),
        .load_data (load_data),
        .ex_srcs   (ex_srcs),
        .wb_fwd    (wb_fwd),
        .fwd       (fwd),
        .stall     (stall)
    );

endmodule

// File: dv/mem_ref_model.svh
// ======================================================================
// reference model for the memory stage testbench
// byte image of the data RAM, load extension and the expected bypass
// and stall values of the hazard unit
// ======================================================================

`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

localparam int ref_addr_w = pipe_pkg::ram_idx_w + 2;

// byte image, zero like the RAM at time zero
logic [7:0] ref_mem [pipe_pkg::ram_words*4] = '{default: 8'h00};

// addresses wrap at the RAM size
function automatic logic [ref_addr_w-1:0] byte_index(input logic [31:0] addr);
    return addr[ref_addr_w-1:0];
endfunction

function automatic int size_bytes(input pipe_pkg::mem_size_e size);
    case (size)
        pipe_pkg::size_byte: return 1;
        pipe_pkg::size_half: return 2;
        default:             return 4;
    endcase
endfunction

function automatic void ref_store(input logic [31:0] addr, input pipe_pkg::mem_size_e size,
                                  input logic [31:0] data);
    for (int i = 0; i < size_bytes(size); i++) begin
        ref_mem[byte_index(addr + 32'(i))] = data[8*i +: 8];
    end
endfunction

function automatic logic [31:0] ref_load(input logic [31:0] addr,
                                         input pipe_pkg::mem_size_e size,
                                         input logic is_unsigned);
    logic [31:0] raw;
    int          n;
    n   = size_bytes(size);
    raw = '0;
    for (int i = 0; i < n; i++) begin
        raw[8*i +: 8] = ref_mem[byte_index(addr + 32'(i))];
    end
    // sign fill above the loaded bytes
    if (!is_unsigned && n < 4 && raw[8*n-1]) begin
        for (int i = n; i < 4; i++) begin
            raw[8*i +: 8] = 8'hff;
        end
    end
    return raw;
endfunction

function automatic void ref_source(input logic [pipe_pkg::reg_idx_w-1:0] rs,
                                   input pipe_pkg::ex_mem_t m, input pipe_pkg::wb_fwd_t wbf,
                                   input logic done_e, input logic [31:0] load_val,
                                   output logic hit, output logic [31:0] data);
    logic mem_writes;
    mem_writes = m.valid && m.write_gpr && !m.mem_write;
    hit        = 1'b0;
    data       = '0;
    if (rs != '0 && mem_writes && m.rd == rs) begin
        // memory stage owns rs, a pending load supplies nothing
        if (!m.mem_read) begin
            hit  = 1'b1;
            data = m.alu_out;
        end else if (done_e) begin
            hit  = 1'b1;
            data = load_val;
        end
    end else if (rs != '0 && wbf.write_gpr && wbf.rd == rs) begin
        hit  = 1'b1;
        data = wbf.data;
    end
endfunction

function automatic pipe_pkg::fwd_t ref_fwd(input pipe_pkg::ex_mem_t m,
                                           input pipe_pkg::ex_srcs_t srcs,
                                           input pipe_pkg::wb_fwd_t wbf,
                                           input logic done_e, input logic [31:0] load_val);
    pipe_pkg::fwd_t f;
    ref_source(srcs.rs1, m, wbf, done_e, load_val, f.rs1_hit, f.rs1_data);
    ref_source(srcs.rs2, m, wbf, done_e, load_val, f.rs2_hit, f.rs2_data);
    return f;
endfunction

function automatic pipe_pkg::stall_t ref_stall(input pipe_pkg::ex_mem_t m,
                                               input pipe_pkg::ex_srcs_t srcs,
                                               input logic busy_e, input logic done_e);
    pipe_pkg::stall_t s;
    logic             load_use;
    load_use = m.valid && m.write_gpr && m.mem_read && !m.mem_write && !done_e
            && m.rd != '0 && (m.rd == srcs.rs1 || m.rd == srcs.rs2);
    s.stall_mem = busy_e;
    s.stall_ex  = busy_e || load_use;
    s.stall_id  = busy_e || load_use;
    s.stall_if  = busy_e || load_use;
    return s;
endfunction

`endif

// File: dv/tb_mem_stage.sv
// ======================================================================
// testbench for the memory access stage
// random bundles from a fixed seed, checked cycle by cycle against
// the reference model
// ======================================================================

`timescale 1ns/10ps

module tb_mem_stage;

    localparam int max_wait = 20;
    localparam int settle   = 10;

    logic               clk = 1'b0;
    logic               rst_n;
    pipe_pkg::ex_mem_t  mem_in;
    pipe_pkg::ex_srcs_t ex_srcs;
    pipe_pkg::wb_fwd_t  wb_fwd;
    pipe_pkg::mem_wb_t  wb_out;
    pipe_pkg::fwd_t     fwd;
    pipe_pkg::stall_t   stall;
    pipe_pkg::mem_wb_t  idle_wb;
    logic [31:0]        next_pc;

    `include "mem_ref_model.svh"

    mem_stage i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_in  (mem_in),
        .ex_srcs (ex_srcs),
        .wb_fwd  (wb_fwd),
        .wb_out  (wb_out),
        .fwd     (fwd),
        .stall   (stall)
    );

    always #50 clk = ~clk;

    // ==================================================================
    // checks
    // ==================================================================

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // payload is only compared on a valid pulse
    task automatic check_wb(input pipe_pkg::mem_wb_t exp, input pipe_pkg::mem_wb_t act);
        if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
            abort_run($sformatf({"** Error @ %0t: wb_out expected v%0b pc %h rd %0d wr %0b %h,",
                                 " got v%0b pc %h rd %0d wr %0b %h"}, $time,
                                exp.valid, exp.pc, exp.rd, exp.write_gpr, exp.result,
                                act.valid, act.pc, act.rd, act.write_gpr, act.result));
        end
    endtask

    task automatic check_fwd(input pipe_pkg::fwd_t exp, input pipe_pkg::fwd_t act);
        if (act !== exp) begin
            abort_run($sformatf({"** Error @ %0t: fwd expected rs1 %0b/%h rs2 %0b/%h,",
                                 " got rs1 %0b/%h rs2 %0b/%h"}, $time,
                                exp.rs1_hit, exp.rs1_data, exp.rs2_hit, exp.rs2_data,
                                act.rs1_hit, act.rs1_data, act.rs2_hit, act.rs2_data));
        end
    endtask

    task automatic check_stall(input pipe_pkg::stall_t exp, input pipe_pkg::stall_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error @ %0t: stall if/id/ex/mem expected %b, got %b",
                                $time, exp, act));
        end
    endtask

    task automatic check_reset_outputs();
        check_wb(idle_wb, wb_out);
        check_stall('0, stall);
        if ({i_dut.awvalid, i_dut.wvalid, i_dut.arvalid, i_dut.bvalid, i_dut.rvalid} !== 5'b0) begin
            abort_run($sformatf("** Error @ %0t: AXI valids aw/w/ar/b/r expected 00000, got %b",
                                $time, {i_dut.awvalid, i_dut.wvalid, i_dut.arvalid,
                                        i_dut.bvalid, i_dut.rvalid}));
        end
    endtask

    // ==================================================================
    // stimulus
    // ==================================================================

    function automatic logic [pipe_pkg::reg_idx_w-1:0] pick_src();
        case ($urandom % 4)
            0:       return '0;
            1:       return mem_in.rd;
            2:       return wb_fwd.rd;
            default: return 5'($urandom);
        endcase
    endfunction

    function automatic pipe_pkg::mem_size_e rand_size();
        case ($urandom % 3)
            0:       return pipe_pkg::size_byte;
            1:       return pipe_pkg::size_half;
            default: return pipe_pkg::size_word;
        endcase
    endfunction

    function automatic logic [1:0] rand_offset(input pipe_pkg::mem_size_e size);
        logic [1:0] off;
        off = 2'($urandom);
        case (size)
            pipe_pkg::size_byte: return off;
            pipe_pkg::size_half: return {off[1], 1'b0};
            default:             return 2'b00;
        endcase
    endfunction

    // small word window so loads find earlier stores, upper bits random
    function automatic logic [31:0] rand_addr(input logic [1:0] off);
        logic [31:0] a;
        a = $urandom;
        a[pipe_pkg::ram_idx_w+1:6] = '0;
        a[1:0] = off;
        return a;
    endfunction

    function automatic pipe_pkg::ex_mem_t base_bundle();
        pipe_pkg::ex_mem_t b;
        b            = '0;
        b.valid      = 1'b1;
        b.pc         = next_pc;
        next_pc      = next_pc + 32'd4;
        b.rd         = 5'($urandom);
        b.write_gpr  = 1'($urandom);
        b.size       = pipe_pkg::size_word;
        b.alu_out    = $urandom;
        b.store_data = $urandom;
        return b;
    endfunction

    function automatic pipe_pkg::ex_mem_t make_access(input logic write, input logic [31:0] addr,
                                                      input pipe_pkg::mem_size_e size,
                                                      input logic is_unsigned);
        pipe_pkg::ex_mem_t b;
        b             = base_bundle();
        b.mem_read    = !write;
        b.mem_write   = write;
        b.size        = size;
        b.is_unsigned = is_unsigned;
        b.alu_out     = addr;
        return b;
    endfunction

    function automatic pipe_pkg::ex_mem_t random_bundle();
        pipe_pkg::ex_mem_t   b;
        pipe_pkg::mem_size_e sz;
        sz = rand_size();
        case ($urandom % 4)
            0: begin
                b          = base_bundle();
                b.valid    = 1'b0;
                b.mem_read = 1'($urandom);
            end
            1:       b = make_access(1'b1, rand_addr(rand_offset(sz)), sz, 1'b0);
            2:       b = make_access(1'b0, rand_addr(rand_offset(sz)), sz, 1'($urandom));
            default: b = base_bundle();
        endcase
        return b;
    endfunction

    // new execute sources and writeback view, then compare bypass and stalls
    task automatic check_side(input logic busy_e, input logic done_e, input logic [31:0] load_val);
        wb_fwd.write_gpr = 1'($urandom);
        wb_fwd.rd        = ($urandom % 2 == 0) ? mem_in.rd : 5'($urandom);
        wb_fwd.data      = $urandom;
        ex_srcs.rs1      = pick_src();
        ex_srcs.rs2      = pick_src();
        #settle;
        check_fwd(ref_fwd(mem_in, ex_srcs, wb_fwd, done_e, load_val), fwd);
        check_stall(ref_stall(mem_in, ex_srcs, busy_e, done_e), stall);
    endtask

    // present one bundle, follow it to its writeback pulse, then hold it
    task automatic run_bundle(input pipe_pkg::ex_mem_t b, input int hold);
        pipe_pkg::mem_wb_t exp_wb;
        logic              is_mem;
        logic [31:0]       load_val;
        int                lat;
        int                cyc;
        logic              seen;
        is_mem   = b.valid && (b.mem_read || b.mem_write);
        lat      = is_mem ? 3 : 1;
        load_val = '0;
        if (b.valid && b.mem_write) begin
            ref_store(b.alu_out, b.size, b.store_data);
        end else if (b.valid && b.mem_read) begin
            load_val = ref_load(b.alu_out, b.size, b.is_unsigned);
        end
        exp_wb = '{valid: 1'b1, pc: b.pc, rd: b.rd,
                   write_gpr: b.write_gpr && !b.mem_write,
                   result: b.mem_read ? load_val : b.alu_out};
        mem_in = b;
        if (!b.valid) begin
            check_side(1'b0, 1'b0, load_val);
            @(negedge clk);
            check_wb(idle_wb, wb_out);
            return;
        end
        cyc  = 0;
        seen = 1'b0;
        while (!seen) begin
            if (cyc == max_wait) begin
                abort_run($sformatf("timeout: no wb_out.valid within %0d cycles for pc %h",
                                    max_wait, b.pc));
            end
            // memory access busy in cycles 0 and 1, done in cycle 2
            check_side(is_mem && cyc < 2, is_mem && cyc == 2, load_val);
            @(negedge clk);
            cyc++;
            if (wb_out.valid === 1'b1) begin
                if (cyc != lat) begin
                    abort_run($sformatf("wb_out.valid for pc %h came after %0d cycles, not %0d",
                                        b.pc, cyc, lat));
                end
                check_wb(exp_wb, wb_out);
                seen = 1'b1;
            end
        end
        for (int h = 0; h < hold; h++) begin
            check_side(1'b0, 1'b0, load_val);
            @(negedge clk);
            check_wb(idle_wb, wb_out);
        end
    endtask

    // ==================================================================
    // test sequence
    // ==================================================================

    initial begin
        logic [31:0]         addrs [16];
        pipe_pkg::mem_size_e sz;
        pipe_pkg::ex_mem_t   b;
        void'($urandom(83));
        rst_n   = 1'b0;
        mem_in  = '0;
        ex_srcs = '0;
        wb_fwd  = '0;
        idle_wb = '0;
        next_pc = 32'h0000_1000;

        repeat (3) begin
            @(negedge clk);
            check_reset_outputs();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_outputs();

        // word round trip
        for (int i = 0; i < 16; i++) begin
            addrs[i] = rand_addr(2'b00);
            run_bundle(make_access(1'b1, addrs[i], pipe_pkg::size_word, 1'b0), 0);
        end
        for (int i = 0; i < 16; i++) begin
            b = make_access(1'b0, addrs[i], pipe_pkg::size_word, 1'b0);
            run_bundle(b, int'($urandom % 2));
        end

        // byte and halfword stores on every legal offset, then mixed loads
        for (int i = 0; i < 24; i++) begin
            sz = (i < 16) ? pipe_pkg::size_byte : pipe_pkg::size_half;
            b  = make_access(1'b1, rand_addr(sz == pipe_pkg::size_byte ? 2'(i) : 2'(i * 2)),
                             sz, 1'b0);
            run_bundle(b, 0);
        end
        for (int i = 0; i < 32; i++) begin
            sz = rand_size();
            b  = make_access(1'b0, rand_addr(rand_offset(sz)), sz, 1'($urandom));
            run_bundle(b, int'($urandom % 3));
        end

        // non-memory and invalid bundles
        for (int i = 0; i < 24; i++) begin
            b = base_bundle();
            if ($urandom % 4 == 0) begin
                b.valid    = 1'b0;
                b.mem_read = 1'($urandom);
            end
            run_bundle(b, int'($urandom % 2));
        end

        // everything mixed, with held bundles
        for (int i = 0; i < 64; i++) begin
            run_bundle(random_bundle(), int'($urandom % 3));
        end

        $display("Test OK");
        $finish;
    end

endmodule

// File: all.f
+incdir+dv
source/pipe_pkg.sv
source/axi_lite_pkg.sv
source/load_store_unit.sv
source/data_ram_axi.sv
source/hazard_forward.sv
source/mem_stage.sv
dv/tb_mem_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the memory stage testbench with Verilator and run it
# exit status is non-zero when the build fails or the testbench stops on $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/10ps --top-module tb_mem_stage \
    -f all.f -o tb_mem_stage \
    && ./obj_dir/tb_mem_stage \
    || { echo "memory stage simulation did not pass"; exit 1; }
